//--- memStagePkg.sv
package memStagePkg;

    // word address width of the data RAM
    localparam int ramAddrBits = 8;

    // cycles that PREADY stays low in the access phase
    localparam int ramWaitStates = 1;

    typedef enum logic [3:0] {
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opLwl,
        opLwr,
        opSb,
        opSh,
        opSw,
        opSwl,
        opSwr
    } memOp_e;

    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stAccess,
        stDone
    } ctrlState_e;

    // request from the upstream stage
    typedef struct packed {
        memOp_e      op;
        logic [31:0] addr;
        logic [31:0] storeData;
        // current destination register, merged into by lwl and lwr
        logic [31:0] oldRegValue;
        logic [4:0]  regId;
    } memReq_t;

    typedef struct packed {
        logic [4:0]  regId;
        logic [31:0] data;
        logic [3:0]  byteEnable;
        logic        alignFault;
    } wbResult_t;

    // store data already placed on its memory byte lanes
    typedef struct packed {
        logic [31:0] wdata;
        logic [3:0]  strb;
    } storeLanes_t;

endpackage

//--- storeAlign.sv
module storeAlign (
    input  memStagePkg::memOp_e      op,
    input  logic [31:0]              addr,
    input  logic [31:0]              storeData,
    output memStagePkg::storeLanes_t lanes
);

    logic [1:0] offset;
    logic [4:0] upShift;
    logic [4:0] downShift;

    assign offset = addr[1:0];
    assign upShift = {offset, 3'b000};
    // swl moves the top register bytes down to lane 0, so it shifts by 3 - offset bytes
    assign downShift = {~offset, 3'b000};

    always_comb begin
        lanes.wdata = storeData << upShift;
        lanes.strb = 4'b0000;
        case (op)
            memStagePkg::opSb: begin
                lanes.strb = 4'b0001 << offset;
            end
            memStagePkg::opSh: begin
                lanes.strb = 4'b0011 << offset;
            end
            memStagePkg::opSw: begin
                lanes.strb = 4'b1111;
            end
            memStagePkg::opSwl: begin
                // register bytes 3-k..3 land on lanes 0..k
                lanes.wdata = storeData >> downShift;
                lanes.strb = 4'b1111 >> ~offset;
            end
            memStagePkg::opSwr: begin
                // register bytes 0..3-k land on lanes k..3
                lanes.strb = 4'b1111 << offset;
            end
            default: begin
                lanes.wdata = '0;
            end
        endcase
    end

endmodule

//--- loadAlign.sv
module loadAlign (
    input  memStagePkg::memOp_e op,
    input  logic [31:0]         addr,
    input  logic [31:0]         rdata,
    input  logic [31:0]         oldRegValue,
    output logic [31:0]         data,
    output logic [3:0]          byteEnable
);

    logic [1:0]  offset;
    logic [31:0] downData;
    logic [31:0] upData;
    logic [3:0]  mergeEnable;
    logic [31:0] mergeMask;

    assign offset = addr[1:0];
    // the addressed byte or halfword moved down to bit 0
    assign downData = rdata >> {offset, 3'b000};
    // lanes 0..k moved up so that lane k lands in register byte 3
    assign upData = rdata << {~offset, 3'b000};

    always_comb begin
        case (op)
            memStagePkg::opLwl: mergeEnable = 4'b1111 << ~offset;
            memStagePkg::opLwr: mergeEnable = 4'b1111 >> offset;
            default: mergeEnable = 4'b1111;
        endcase
    end

    assign mergeMask = {{8{mergeEnable[3]}}, {8{mergeEnable[2]}},
                        {8{mergeEnable[1]}}, {8{mergeEnable[0]}}};

    always_comb begin
        data = '0;
        byteEnable = 4'b1111;
        case (op)
            memStagePkg::opLb: begin
                data = {{24{downData[7]}}, downData[7:0]};
            end
            memStagePkg::opLbu: begin
                data = {24'h000000, downData[7:0]};
            end
            memStagePkg::opLh: begin
                data = {{16{downData[15]}}, downData[15:0]};
            end
            memStagePkg::opLhu: begin
                data = {16'h0000, downData[15:0]};
            end
            memStagePkg::opLw: begin
                data = rdata;
            end
            memStagePkg::opLwl: begin
                data = (upData & mergeMask) | (oldRegValue & ~mergeMask);
                byteEnable = mergeEnable;
            end
            memStagePkg::opLwr: begin
                data = (downData & mergeMask) | (oldRegValue & ~mergeMask);
                byteEnable = mergeEnable;
            end
            default: begin
                // stores write nothing back to the register file
                byteEnable = 4'b0000;
            end
        endcase
    end

endmodule

//--- memAccessCtrl.sv
module memAccessCtrl (
    input  logic                                   Clk,
    input  logic                                   rstN,
    input  logic                                   reqValid,
    input  memStagePkg::memReq_t                   req,
    output logic                                   reqReady,
    input  memStagePkg::storeLanes_t               storeLanes,
    input  logic [31:0]                            loadData,
    input  logic [3:0]                             loadByteEnable,
    output memStagePkg::memReq_t                   curReq,
    output logic                                   psel,
    output logic                                   penable,
    output logic                                   pwrite,
    output logic [memStagePkg::ramAddrBits-1:0]    paddr,
    output logic [31:0]                            pwdata,
    output logic [3:0]                             pstrb,
    input  logic                                   pready,
    output logic                                   wbValid,
    output memStagePkg::wbResult_t                 wb
);

    memStagePkg::ctrlState_e state;
    logic accept;
    logic misaligned;

    assign accept = reqValid && reqReady;

    always_comb begin
        case (req.op)
            memStagePkg::opLh,
            memStagePkg::opLhu,
            memStagePkg::opSh: misaligned = req.addr[0];
            memStagePkg::opLw,
            memStagePkg::opSw: misaligned = |req.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= memStagePkg::stIdle;
            reqReady <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= 1'b0;
            case (state)
                memStagePkg::stIdle: begin
                    if (accept) begin
                        reqReady <= 1'b0;
                        // a fault skips the bus and reports on the next cycle
                        state <= misaligned ? memStagePkg::stDone : memStagePkg::stSetup;
                    end else begin
                        reqReady <= 1'b1;
                    end
                end
                memStagePkg::stSetup: begin
                    state <= memStagePkg::stAccess;
                end
                memStagePkg::stAccess: begin
                    if (pready) begin
                        state <= memStagePkg::stDone;
                    end
                end
                memStagePkg::stDone: begin
                    wbValid <= 1'b1;
                    reqReady <= 1'b1;
                    state <= memStagePkg::stIdle;
                end
                default: begin
                    state <= memStagePkg::stIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            curReq <= req;
            wb.regId <= req.regId;
            wb.data <= '0;
            wb.byteEnable <= 4'b0000;
            wb.alignFault <= misaligned;
        end else if (state == memStagePkg::stAccess && pready) begin
            wb.regId <= curReq.regId;
            wb.data <= loadData;
            wb.byteEnable <= loadByteEnable;
            wb.alignFault <= 1'b0;
        end
    end

    assign psel = (state == memStagePkg::stSetup) || (state == memStagePkg::stAccess);
    assign penable = (state == memStagePkg::stAccess);
    assign pwrite = (curReq.op == memStagePkg::opSb) || (curReq.op == memStagePkg::opSh) ||
                    (curReq.op == memStagePkg::opSw) || (curReq.op == memStagePkg::opSwl) ||
                    (curReq.op == memStagePkg::opSwr);
    assign paddr = curReq.addr[memStagePkg::ramAddrBits+1:2];
    assign pwdata = storeLanes.wdata;
    // load opcodes already come back from the store aligner with zero strobes
    assign pstrb = storeLanes.strb;

    penableAfterPsel: assert property (@(posedge Clk) disable iff (!rstN)
        penable |-> $past(psel));

    apbHoldStable: assert property (@(posedge Clk) disable iff (!rstN)
        psel && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata));

    wbSinglePulse: assert property (@(posedge Clk) disable iff (!rstN)
        wbValid |=> !wbValid);

endmodule

//--- apbDataRam.sv
module apbDataRam (
    input  logic                                Clk,
    input  logic                                rstN,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [memStagePkg::ramAddrBits-1:0] paddr,
    input  logic [31:0]                         pwdata,
    input  logic [3:0]                          pstrb,
    output logic [31:0]                         prdata,
    output logic                                pready
);

    logic [31:0] mem [2**memStagePkg::ramAddrBits];
    logic [3:0]  waitCnt;
    logic        accessPhase;

    assign accessPhase = psel && penable;
    // ready once the access phase has sat through all wait states
    assign pready = accessPhase && (waitCnt == 4'(memStagePkg::ramWaitStates));
    assign prdata = (pready && !pwrite) ? mem[paddr] : '0;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            waitCnt <= '0;
        end else if (accessPhase && !pready) begin
            waitCnt <= waitCnt + 4'd1;
        end else begin
            waitCnt <= '0;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**memStagePkg::ramAddrBits; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    mem[paddr][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    readStrobeZero: assert property (@(posedge Clk) disable iff (!rstN)
        psel && !pwrite |-> pstrb == 4'b0000);

endmodule

//--- memStageTop.sv
module memStageTop (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   reqValid,
    input  memStagePkg::memReq_t   req,
    output logic                   reqReady,
    output logic                   wbValid,
    output memStagePkg::wbResult_t wb
);

    memStagePkg::memReq_t                curReq;
    memStagePkg::storeLanes_t            storeLanes;
    logic [31:0]                         loadData;
    logic [3:0]                          loadByteEnable;
    logic                                psel;
    logic                                penable;
    logic                                pwrite;
    logic [memStagePkg::ramAddrBits-1:0] paddr;
    logic [31:0]                         pwdata;
    logic [3:0]                          pstrb;
    logic [31:0]                         prdata;
    logic                                pready;

    memAccessCtrl ctrl (
        .Clk(Clk),
        .rstN(rstN),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .storeLanes(storeLanes),
        .loadData(loadData),
        .loadByteEnable(loadByteEnable),
        .curReq(curReq),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .pready(pready),
        .wbValid(wbValid),
        .wb(wb)
    );

    storeAlign storeAligner (
        .op(curReq.op),
        .addr(curReq.addr),
        .storeData(curReq.storeData),
        .lanes(storeLanes)
    );

    loadAlign loadAligner (
        .op(curReq.op),
        .addr(curReq.addr),
        .rdata(prdata),
        .oldRegValue(curReq.oldRegValue),
        .data(loadData),
        .byteEnable(loadByteEnable)
    );

    apbDataRam ram (
        .Clk(Clk),
        .rstN(rstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .pstrb(pstrb),
        .prdata(prdata),
        .pready(pready)
    );

endmodule

//--- memStageTb.sv
module memStageTb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                   Clk = 1'b0;
    logic                   rstN;
    logic                   reqValid;
    memStagePkg::memReq_t   req;
    logic                   reqReady;
    logic                   wbValid;
    memStagePkg::wbResult_t wb;

    integer seed = 98;
    int checkCount = 0;
    int errorCount = 0;
    int testChecks;
    int testErrors;

    // request counts of each test, the watchdog is sized from them
    int wordPairs = 200;
    int subWordCount = 200;
    int unalignedCount = 200;
    int faultCount = 20;
    int backToBackPairs = 5;

    // byte-addressed copy of the 256-word data RAM
    logic [7:0] modelMem [1024];

    memStagePkg::memOp_e subWordOps [6] = '{memStagePkg::opSb, memStagePkg::opSh,
        memStagePkg::opLb, memStagePkg::opLbu, memStagePkg::opLh, memStagePkg::opLhu};
    memStagePkg::memOp_e unalignedOps [4] = '{memStagePkg::opLwl, memStagePkg::opLwr,
        memStagePkg::opSwl, memStagePkg::opSwr};
    memStagePkg::memOp_e faultOps [5] = '{memStagePkg::opLh, memStagePkg::opLhu,
        memStagePkg::opSh, memStagePkg::opLw, memStagePkg::opSw};

    memStageTop dut (
        .Clk(Clk),
        .rstN(rstN),
        .reqValid(reqValid),
        .req(req),
        .reqReady(reqReady),
        .wbValid(wbValid),
        .wb(wb)
    );

    always #5 Clk = ~Clk;

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    // a byte address inside a 32-word window, so that loads often hit stored data
    function automatic logic [9:0] windowAddr();
        logic [31:0] rnd;
        rnd = randWord();
        return {3'b000, rnd[6:0]};
    endfunction

    function automatic memStagePkg::memReq_t makeReq(memStagePkg::memOp_e op,
                                                     logic [9:0] byteAddr);
        memStagePkg::memReq_t r;
        logic [31:0] rnd;
        rnd = randWord();
        // the bits above the RAM address are random and must be ignored
        r.addr = {rnd[31:10], byteAddr};
        r.op = op;
        r.regId = rnd[4:0];
        r.storeData = randWord();
        r.oldRegValue = randWord();
        return r;
    endfunction

    task automatic modelAccess(input memStagePkg::memReq_t r, output memStagePkg::wbResult_t e);
        int base;
        int k;
        logic [7:0] m [4];
        logic [7:0] regByte [4];
        logic [7:0] storeByte [4];
        logic sign;
        base = int'(r.addr[9:2]) * 4;
        k = int'(r.addr[1:0]);
        e.regId = r.regId;
        e.data = '0;
        e.byteEnable = 4'b0000;
        e.alignFault = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m[i] = modelMem[base + i];
            regByte[i] = r.oldRegValue[8*i +: 8];
            storeByte[i] = r.storeData[8*i +: 8];
        end
        case (r.op)
            memStagePkg::opLb, memStagePkg::opLbu: begin
                sign = (r.op == memStagePkg::opLb) && m[k][7];
                e.data = {{24{sign}}, m[k]};
                e.byteEnable = 4'b1111;
            end
            memStagePkg::opLh, memStagePkg::opLhu: begin
                if (k % 2 == 0) begin
                    sign = (r.op == memStagePkg::opLh) && m[k + 1][7];
                    e.data = {{16{sign}}, m[k + 1], m[k]};
                    e.byteEnable = 4'b1111;
                end else begin
                    e.alignFault = 1'b1;
                end
            end
            memStagePkg::opLw: begin
                if (k == 0) begin
                    e.data = {m[3], m[2], m[1], m[0]};
                    e.byteEnable = 4'b1111;
                end else begin
                    e.alignFault = 1'b1;
                end
            end
            memStagePkg::opLwl: begin
                for (int i = 0; i <= k; i++) begin
                    regByte[3 - k + i] = m[i];
                    e.byteEnable[3 - k + i] = 1'b1;
                end
                e.data = {regByte[3], regByte[2], regByte[1], regByte[0]};
            end
            memStagePkg::opLwr: begin
                for (int i = k; i < 4; i++) begin
                    regByte[i - k] = m[i];
                    e.byteEnable[i - k] = 1'b1;
                end
                e.data = {regByte[3], regByte[2], regByte[1], regByte[0]};
            end
            memStagePkg::opSb: begin
                modelMem[base + k] = storeByte[0];
            end
            memStagePkg::opSh: begin
                if (k % 2 == 0) begin
                    modelMem[base + k] = storeByte[0];
                    modelMem[base + k + 1] = storeByte[1];
                end else begin
                    e.alignFault = 1'b1;
                end
            end
            memStagePkg::opSw: begin
                if (k == 0) begin
                    for (int i = 0; i < 4; i++) begin
                        modelMem[base + i] = storeByte[i];
                    end
                end else begin
                    e.alignFault = 1'b1;
                end
            end
            memStagePkg::opSwl: begin
                for (int i = 0; i <= k; i++) begin
                    modelMem[base + i] = storeByte[3 - k + i];
                end
            end
            memStagePkg::opSwr: begin
                for (int i = k; i < 4; i++) begin
                    modelMem[base + i] = storeByte[i - k];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        errorCount++;
        $display("[ERROR] at %0t %s: got %h, expected %h", $time, name, got, exp);
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        checkCount++;
        if (got !== exp) begin
            reportMismatch(name, 32'(got), 32'(exp));
        end
    endtask

    task automatic checkLatency(int got, int exp);
        checkCount++;
        if (got != exp) begin
            reportMismatch("wbValid latency", got, exp);
        end
    endtask

    task automatic checkResult(memStagePkg::wbResult_t got, memStagePkg::wbResult_t exp);
        checkCount++;
        if (got.regId !== exp.regId) begin
            reportMismatch("wb.regId", 32'(got.regId), 32'(exp.regId));
        end
        if (got.data !== exp.data) begin
            reportMismatch("wb.data", got.data, exp.data);
        end
        if (got.byteEnable !== exp.byteEnable) begin
            reportMismatch("wb.byteEnable", 32'(got.byteEnable), 32'(exp.byteEnable));
        end
        if (got.alignFault !== exp.alignFault) begin
            reportMismatch("wb.alignFault", 32'(got.alignFault), 32'(exp.alignFault));
        end
    endtask

    task automatic checkHandshake(bit seen, string opName);
        checkCount++;
        if (!seen) begin
            errorCount++;
            $display("at %0t no wbValid pulse came back for an %s request", $time, opName);
        end
    endtask

    task automatic presentRequest(memStagePkg::memReq_t r);
        @(negedge Clk);
        req = r;
        reqValid = 1'b1;
    endtask

    // returns on the falling edge before the accepting rising edge
    task automatic waitAccept(output bit ok);
        int waited;
        waited = 0;
        while (!reqReady && waited < 50) begin
            @(negedge Clk);
            waited++;
        end
        ok = reqReady;
        if (!ok) begin
            errorCount++;
            $display("at %0t a request was never accepted, reqReady stayed low", $time);
        end
    endtask

    task automatic collectResult(input bit haveNext, input memStagePkg::memReq_t nextReq,
                                 output bit seen, output int latency,
                                 output memStagePkg::wbResult_t got);
        int cycles;
        @(negedge Clk);
        cycles = 1;
        if (haveNext) begin
            req = nextReq;
            reqValid = 1'b1;
        end else begin
            reqValid = 1'b0;
        end
        while (!wbValid && cycles < 20) begin
            @(negedge Clk);
            cycles++;
        end
        seen = wbValid;
        latency = cycles - 1;
        got = wb;
    endtask

    task automatic judgeResult(memStagePkg::memReq_t r, memStagePkg::wbResult_t exp, bit seen,
                               int latency, memStagePkg::wbResult_t got);
        checkHandshake(seen, r.op.name());
        if (seen) begin
            checkResult(got, exp);
            checkLatency(latency, exp.alignFault ? 1 : 3 + memStagePkg::ramWaitStates);
        end
    endtask

    task automatic runOne(memStagePkg::memReq_t r);
        memStagePkg::wbResult_t exp;
        memStagePkg::wbResult_t got;
        bit ok;
        bit seen;
        int latency;
        modelAccess(r, exp);
        presentRequest(r);
        waitAccept(ok);
        if (ok) begin
            collectResult(1'b0, r, seen, latency, got);
            judgeResult(r, exp, seen, latency, got);
        end
    endtask

    task automatic runPair(memStagePkg::memReq_t a, memStagePkg::memReq_t b);
        memStagePkg::wbResult_t expA;
        memStagePkg::wbResult_t expB;
        memStagePkg::wbResult_t got;
        bit ok;
        bit seen;
        int latency;
        modelAccess(a, expA);
        modelAccess(b, expB);
        presentRequest(a);
        waitAccept(ok);
        if (ok) begin
            // b shows up on the next falling edge, while the stage is still busy with a
            collectResult(1'b1, b, seen, latency, got);
            judgeResult(a, expA, seen, latency, got);
            waitAccept(ok);
            if (ok) begin
                collectResult(1'b0, b, seen, latency, got);
                judgeResult(b, expB, seen, latency, got);
            end
        end
    endtask

    task automatic checkReset();
        repeat (10) begin
            @(negedge Clk);
            checkBit("wbValid", wbValid, 1'b0);
            checkBit("reqReady", reqReady, 1'b0);
        end
        rstN = 1'b1;
        @(negedge Clk);
        checkBit("wbValid", wbValid, 1'b0);
        checkBit("reqReady", reqReady, 1'b1);
    endtask

    task automatic startTest();
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    task automatic finishTest(string name);
        $display("%s: %0d checks, %0d errors", name, checkCount - testChecks,
                 errorCount - testErrors);
    endtask

    initial begin
        memStagePkg::memReq_t a;
        memStagePkg::memReq_t b;
        logic [31:0] rnd;
        logic [9:0] addr;
        int idx;
        rstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        for (int i = 0; i < 1024; i++) begin
            modelMem[i] = 8'h00;
        end

        startTest();
        checkReset();
        finishTest("reset state");

        startTest();
        repeat (wordPairs) begin
            addr = windowAddr();
            runOne(makeReq(memStagePkg::opSw, {addr[9:2], 2'b00}));
            addr = windowAddr();
            runOne(makeReq(memStagePkg::opLw, {addr[9:2], 2'b00}));
        end
        finishTest("word round trip");

        startTest();
        repeat (subWordCount) begin
            rnd = randWord();
            idx = int'(rnd % 32'd6);
            addr = windowAddr();
            // halfwords stay aligned here, misaligned ones belong to the fault test
            if (subWordOps[idx] inside {memStagePkg::opSh, memStagePkg::opLh,
                                        memStagePkg::opLhu}) begin
                addr[0] = 1'b1 ^ 1'b1;
            end
            runOne(makeReq(subWordOps[idx], addr));
        end
        finishTest("sub-word stores and loads");

        startTest();
        repeat (unalignedCount) begin
            rnd = randWord();
            idx = int'(rnd % 32'd4);
            runOne(makeReq(unalignedOps[idx], windowAddr()));
        end
        finishTest("unaligned word pairs");

        startTest();
        repeat (faultCount) begin
            rnd = randWord();
            idx = int'(rnd % 32'd5);
            addr = windowAddr();
            if (faultOps[idx] inside {memStagePkg::opLw, memStagePkg::opSw}) begin
                // any nonzero offset faults a word access
                if (addr[1:0] == 2'b00) begin
                    addr[1] = 1'b1;
                end
            end else begin
                addr[0] = 1'b1;
            end
            runOne(makeReq(faultOps[idx], addr));
            runOne(makeReq(memStagePkg::opLw, {addr[9:2], 2'b00}));
        end
        finishTest("alignment faults");

        startTest();
        for (int p = 0; p < backToBackPairs; p++) begin
            addr = windowAddr();
            if (p % 2 == 0) begin
                a = makeReq(memStagePkg::opLw, {addr[9:2], 2'b00});
            end else begin
                addr[0] = 1'b1;
                a = makeReq(memStagePkg::opSh, addr);
            end
            addr = windowAddr();
            b = makeReq(memStagePkg::opSw, {addr[9:2], 2'b00});
            runPair(a, b);
            // reading the word back shows that the waiting store really happened
            runOne(makeReq(memStagePkg::opLw, {addr[9:2], 2'b00}));
        end
        finishTest("handshake timing");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        int limitCycles;
        limitCycles = (2 * wordPairs + subWordCount + unalignedCount + 2 * faultCount +
                       3 * backToBackPairs) * 20 + 20;
        #(limitCycles * 10);
        $display("watchdog expired after %0d cycles, the run did not finish", limitCycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- vlog.f
memStagePkg.sv
storeAlign.sv
loadAlign.sv
memAccessCtrl.sv
apbDataRam.sv
memStageTop.sv
memStageTb.sv

//--- Makefile
# Verilator lint, simulation and cleanup for the memory stage

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module memStageTb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module memStageTb -o memStageTb
	./obj_dir/memStageTb | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
